// ==== design/csr_types_pkg.sv ====
`default_nettype none

package csr_types_pkg;

    typedef logic [31:0] csr_word_t;    // data, write mask, address
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;     // ESTAT.IS and ECFG.LIE layout
    typedef logic [7:0]  hw_int_t;
    typedef logic [1:0]  plv_t;

    // new bits where the mask is set, old bits elsewhere
    function automatic csr_word_t masked_merge(
        input csr_word_t old_value,
        input csr_word_t wdata,
        input csr_word_t wmask
    );
        return (wmask & wdata) | (~wmask & old_value);
    endfunction

endpackage

`default_nettype wire

// ==== design/csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

    // CSR numbers
    localparam csr_types_pkg::csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_types_pkg::csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_types_pkg::csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_types_pkg::csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_types_pkg::csr_num_t CSR_ERA    = 14'h006;
    localparam csr_types_pkg::csr_num_t CSR_BADV   = 14'h007;
    localparam csr_types_pkg::csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_types_pkg::csr_num_t CSR_SAVE0  = 14'h030;  // SAVEn at SAVE0 + n
    localparam csr_types_pkg::csr_num_t CSR_TID    = 14'h040;
    localparam csr_types_pkg::csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_types_pkg::csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_types_pkg::csr_num_t CSR_TICLR  = 14'h044;

    // exception codes
    localparam csr_types_pkg::ecode_t    ECODE_ADE     = 6'h08;
    localparam csr_types_pkg::ecode_t    ECODE_ALE     = 6'h09;
    localparam csr_types_pkg::esubcode_t ESUBCODE_ADEF = 9'd0;  // fetch address error

    // fields shared between register groups
    localparam int unsigned CRMD_IE_BIT   = 2;
    localparam int unsigned TICLR_CLR_BIT = 0;

    // performance counter interrupt (bit 10) not implemented
    localparam csr_types_pkg::int_vec_t LIE_WRITABLE = 13'h1bff;

    localparam csr_types_pkg::csr_word_t TIMER_IDLE = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== design/csr_trap_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  wire                             clk,
    input  wire                             reset,
    input  wire csr_types_pkg::csr_num_t    csr_num,
    input  wire                             csr_we,
    input  wire csr_types_pkg::csr_word_t   csr_wmask,
    input  wire csr_types_pkg::csr_word_t   csr_wdata,
    input  wire                             wb_ex,
    input  wire csr_types_pkg::ecode_t      wb_ecode,
    input  wire csr_types_pkg::esubcode_t   wb_esubcode,
    input  wire csr_types_pkg::csr_word_t   wb_pc,
    input  wire csr_types_pkg::csr_word_t   wb_vaddr,
    input  wire                             ertn_flush,
    output logic                            crmd_ie,
    output csr_types_pkg::csr_word_t        crmd_value,
    output csr_types_pkg::csr_word_t        prmd_value,
    output csr_types_pkg::csr_word_t        era_value,
    output csr_types_pkg::csr_word_t        badv_value,
    output csr_types_pkg::csr_word_t        eentry_value,
    output csr_types_pkg::csr_word_t        estat_code_value,
    output csr_types_pkg::csr_word_t        ex_entry
);

    csr_types_pkg::plv_t      crmd_plv;
    logic [5:0]               crmd_mode;    // DATM, DATF, PG, DA
    csr_types_pkg::plv_t      prmd_pplv;
    logic                     prmd_pie;
    csr_types_pkg::ecode_t    estat_ecode;
    csr_types_pkg::esubcode_t estat_esubcode;
    csr_types_pkg::csr_word_t era_pc;
    csr_types_pkg::csr_word_t badv_vaddr;
    logic [19:0]              eentry_va;

    csr_types_pkg::csr_word_t crmd_new;
    csr_types_pkg::csr_word_t prmd_new;
    csr_types_pkg::csr_word_t eentry_new;
    logic                     badv_is_pc;
    logic                     badv_is_vaddr;

    assign crmd_new   = csr_types_pkg::masked_merge(crmd_value, csr_wdata, csr_wmask);
    assign prmd_new   = csr_types_pkg::masked_merge(prmd_value, csr_wdata, csr_wmask);
    assign eentry_new = csr_types_pkg::masked_merge(eentry_value, csr_wdata, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_mode <= 6'b000001;             // DA=1, PG=0
        end else if (wb_ex) begin
            crmd_plv <= '0;                     // kernel, interrupts off
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == csr_addr_pkg::CSR_CRMD) begin
            crmd_plv  <= crmd_new[1:0];
            crmd_ie   <= crmd_new[csr_addr_pkg::CRMD_IE_BIT];
            crmd_mode <= crmd_new[8:3];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;              // save state of interrupted code
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == csr_addr_pkg::CSR_PRMD) begin
            prmd_pplv <= prmd_new[1:0];
            prmd_pie  <= prmd_new[2];
        end
    end

    // ADEF faults on the fetch address, ADEM and ALE on the data address
    assign badv_is_pc    = wb_ecode == csr_addr_pkg::ECODE_ADE
                           && wb_esubcode == csr_addr_pkg::ESUBCODE_ADEF;
    assign badv_is_vaddr = (wb_ecode == csr_addr_pkg::ECODE_ADE
                            && wb_esubcode != csr_addr_pkg::ESUBCODE_ADEF)
                           || wb_ecode == csr_addr_pkg::ECODE_ALE;

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
            if (badv_is_pc) begin
                badv_vaddr <= wb_pc;
            end else if (badv_is_vaddr) begin
                badv_vaddr <= wb_vaddr;
            end
        end else begin
            if (csr_we && csr_num == csr_addr_pkg::CSR_ERA) begin
                era_pc <= csr_types_pkg::masked_merge(era_pc, csr_wdata, csr_wmask);
            end
            if (csr_we && csr_num == csr_addr_pkg::CSR_BADV) begin
                badv_vaddr <= csr_types_pkg::masked_merge(badv_vaddr, csr_wdata, csr_wmask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == csr_addr_pkg::CSR_EENTRY) begin
            eentry_va <= eentry_new[31:12];
        end
    end

    assign crmd_value       = {23'b0, crmd_mode, crmd_ie, crmd_plv};
    assign prmd_value       = {29'b0, prmd_pie, prmd_pplv};
    assign era_value        = era_pc;
    assign badv_value       = badv_vaddr;
    assign eentry_value     = {eentry_va, 12'b0};     // page aligned
    assign estat_code_value = {1'b0, estat_esubcode, estat_ecode, 16'b0};

    assign ex_entry = wb_ex      ? eentry_value :
                      ertn_flush ? era_value    : '0;

    a_ex_ertn_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(wb_ex && ertn_flush));

    a_plv_zero_after_ex: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> crmd_value[1:0] == 2'b0);

endmodule

`default_nettype wire

// ==== design/csr_timer_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer_int (
    input  wire                             clk,
    input  wire                             reset,
    input  wire csr_types_pkg::csr_num_t    csr_num,
    input  wire                             csr_we,
    input  wire csr_types_pkg::csr_word_t   csr_wmask,
    input  wire csr_types_pkg::csr_word_t   csr_wdata,
    input  wire csr_types_pkg::hw_int_t     hw_int_in,
    input  wire                             ipi_int_in,
    input  wire                             crmd_ie,
    output csr_types_pkg::int_vec_t         estat_is,
    output csr_types_pkg::csr_word_t        ecfg_value,
    output csr_types_pkg::csr_word_t        tcfg_value,
    output csr_types_pkg::csr_word_t        tval_value,
    output logic                            has_int
);

    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;

    csr_types_pkg::int_vec_t  ecfg_lie;
    csr_types_pkg::csr_word_t tcfg_q;
    csr_types_pkg::csr_word_t timer_cnt;
    csr_types_pkg::csr_word_t ecfg_new;
    csr_types_pkg::csr_word_t estat_new;
    csr_types_pkg::csr_word_t tcfg_new;
    csr_types_pkg::csr_word_t ticlr_new;
    logic                     tcfg_we;
    logic                     timer_clr;

    assign ecfg_new  = csr_types_pkg::masked_merge(ecfg_value, csr_wdata, csr_wmask);
    assign estat_new = csr_types_pkg::masked_merge({19'b0, estat_is}, csr_wdata, csr_wmask);
    assign tcfg_new  = csr_types_pkg::masked_merge(tcfg_q, csr_wdata, csr_wmask);
    assign ticlr_new = csr_types_pkg::masked_merge('0, csr_wdata, csr_wmask); // reads zero

    assign tcfg_we   = csr_we && csr_num == csr_addr_pkg::CSR_TCFG;
    assign timer_clr = csr_we && csr_num == csr_addr_pkg::CSR_TICLR
                       && ticlr_new[csr_addr_pkg::TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (csr_we && csr_num == csr_addr_pkg::CSR_ECFG) begin
            ecfg_lie <= ecfg_new[12:0] & csr_addr_pkg::LIE_WRITABLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is <= '0;
        end else begin
            if (csr_we && csr_num == csr_addr_pkg::CSR_ESTAT) begin
                estat_is[1:0] <= estat_new[1:0];    // software interrupts
            end
            estat_is[9:2] <= hw_int_in;             // sampled every cycle
            estat_is[10]  <= 1'b0;
            if (timer_cnt == '0) begin
                estat_is[11] <= 1'b1;               // expiry beats a clear
            end else if (timer_clr) begin
                estat_is[11] <= 1'b0;
            end
            estat_is[12] <= ipi_int_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_q <= '0;
        end else if (tcfg_we) begin
            tcfg_q <= tcfg_new;
        end
    end

    // one-shot underflows 0 -> all ones and then holds as idle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= csr_addr_pkg::TIMER_IDLE;
        end else if (tcfg_we && tcfg_new[TCFG_EN]) begin
            timer_cnt <= {tcfg_new[31:2], 2'b00};   // InitVal * 4
        end else if (tcfg_q[TCFG_EN] && timer_cnt != csr_addr_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_q[TCFG_PERIODIC]) begin
                timer_cnt <= {tcfg_q[31:2], 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign ecfg_value = {19'b0, ecfg_lie};
    assign tcfg_value = tcfg_q;
    assign tval_value = timer_cnt;

    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

    a_lie10_clear: assert property (@(posedge clk) disable iff (reset)
        ecfg_value[10] == 1'b0);

    a_idle_holds: assert property (@(posedge clk) disable iff (reset)
        (timer_cnt == csr_addr_pkg::TIMER_IDLE && !tcfg_we)
        |=> timer_cnt == csr_addr_pkg::TIMER_IDLE);

endmodule

`default_nettype wire

// ==== design/csr_scratch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire csr_types_pkg::csr_num_t                csr_num,
    input  wire                                         csr_we,
    input  wire csr_types_pkg::csr_word_t               csr_wmask,
    input  wire csr_types_pkg::csr_word_t               csr_wdata,
    input  wire csr_types_pkg::csr_word_t               coreid_in,
    output csr_types_pkg::csr_word_t [SAVE_COUNT-1:0]   save_values,
    output csr_types_pkg::csr_word_t                    tid_value
);

    // plain software scratch storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_we
                && csr_num == csr_types_pkg::csr_num_t'(csr_addr_pkg::CSR_SAVE0 + i)) begin
                save_values[i] <= csr_types_pkg::masked_merge(save_values[i], csr_wdata,
                                                              csr_wmask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_value <= coreid_in;             // core id captured in reset
        end else if (csr_we && csr_num == csr_addr_pkg::CSR_TID) begin
            tid_value <= csr_types_pkg::masked_merge(tid_value, csr_wdata, csr_wmask);
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  wire csr_types_pkg::csr_num_t                csr_num,
    input  wire csr_types_pkg::csr_word_t               crmd_value,
    input  wire csr_types_pkg::csr_word_t               prmd_value,
    input  wire csr_types_pkg::csr_word_t               era_value,
    input  wire csr_types_pkg::csr_word_t               badv_value,
    input  wire csr_types_pkg::csr_word_t               eentry_value,
    input  wire csr_types_pkg::csr_word_t               estat_code_value,
    input  wire csr_types_pkg::int_vec_t                estat_is,
    input  wire csr_types_pkg::csr_word_t               ecfg_value,
    input  wire csr_types_pkg::csr_word_t               tcfg_value,
    input  wire csr_types_pkg::csr_word_t               tval_value,
    input  wire csr_types_pkg::csr_word_t [SAVE_COUNT-1:0] save_values,
    input  wire csr_types_pkg::csr_word_t               tid_value,
    output csr_types_pkg::csr_word_t                    csr_rvalue
);

    always_comb begin
        csr_rvalue = '0;                        // TICLR and unknown numbers
        case (csr_num)
            csr_addr_pkg::CSR_CRMD:   csr_rvalue = crmd_value;
            csr_addr_pkg::CSR_PRMD:   csr_rvalue = prmd_value;
            csr_addr_pkg::CSR_ECFG:   csr_rvalue = ecfg_value;
            csr_addr_pkg::CSR_ESTAT:  csr_rvalue = {estat_code_value[31:13], estat_is};
            csr_addr_pkg::CSR_ERA:    csr_rvalue = era_value;
            csr_addr_pkg::CSR_BADV:   csr_rvalue = badv_value;
            csr_addr_pkg::CSR_EENTRY: csr_rvalue = eentry_value;
            csr_addr_pkg::CSR_TID:    csr_rvalue = tid_value;
            csr_addr_pkg::CSR_TCFG:   csr_rvalue = tcfg_value;
            csr_addr_pkg::CSR_TVAL:   csr_rvalue = tval_value;
        endcase
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_num == csr_types_pkg::csr_num_t'(csr_addr_pkg::CSR_SAVE0 + i)) begin
                csr_rvalue = save_values[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter int SAVE_COUNT = 4                // 1 to 4 SAVE registers
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire csr_types_pkg::csr_num_t    csr_num,
    input  wire                             csr_we,
    input  wire csr_types_pkg::csr_word_t   csr_wmask,
    input  wire csr_types_pkg::csr_word_t   csr_wdata,
    input  wire csr_types_pkg::hw_int_t     hw_int_in,
    input  wire                             ipi_int_in,
    input  wire                             wb_ex,
    input  wire csr_types_pkg::ecode_t      wb_ecode,
    input  wire csr_types_pkg::esubcode_t   wb_esubcode,
    input  wire csr_types_pkg::csr_word_t   wb_pc,
    input  wire csr_types_pkg::csr_word_t   wb_vaddr,
    input  wire                             ertn_flush,
    input  wire csr_types_pkg::csr_word_t   coreid_in,
    output csr_types_pkg::csr_word_t        csr_rvalue,
    output csr_types_pkg::csr_word_t        ex_entry,
    output logic                            has_int
);

    logic                                     crmd_ie;
    csr_types_pkg::csr_word_t                 crmd_value;
    csr_types_pkg::csr_word_t                 prmd_value;
    csr_types_pkg::csr_word_t                 era_value;
    csr_types_pkg::csr_word_t                 badv_value;
    csr_types_pkg::csr_word_t                 eentry_value;
    csr_types_pkg::csr_word_t                 estat_code_value;
    csr_types_pkg::int_vec_t                  estat_is;
    csr_types_pkg::csr_word_t                 ecfg_value;
    csr_types_pkg::csr_word_t                 tcfg_value;
    csr_types_pkg::csr_word_t                 tval_value;
    csr_types_pkg::csr_word_t [SAVE_COUNT-1:0] save_values;
    csr_types_pkg::csr_word_t                 tid_value;

    csr_trap_regs u_trap (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wdata,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr, .ertn_flush,
        .crmd_ie, .crmd_value, .prmd_value, .era_value, .badv_value,
        .eentry_value, .estat_code_value, .ex_entry
    );

    csr_timer_int u_timer (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wdata,
        .hw_int_in, .ipi_int_in, .crmd_ie,
        .estat_is, .ecfg_value, .tcfg_value, .tval_value, .has_int
    );

    csr_scratch_regs #(.SAVE_COUNT(SAVE_COUNT)) u_scratch (
        .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wdata, .coreid_in,
        .save_values, .tid_value
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) u_rmux (
        .csr_num, .crmd_value, .prmd_value, .era_value, .badv_value,
        .eentry_value, .estat_code_value, .estat_is, .ecfg_value,
        .tcfg_value, .tval_value, .save_values, .tid_value, .csr_rvalue
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;      // 50% duty
    end

endmodule

`default_nettype wire

// ==== dv/csr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

    localparam int SAVE_COUNT    = 4;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_WRITES = 200;
    localparam int RANDOM_SEED   = 96;
    localparam int TIMER_INIT    = 6;           // counter starts at 24
    localparam int RUN_CYCLES    = RESET_CYCLES + 2 * RANDOM_WRITES + 4 * TIMER_INIT * 4 + 300;

    logic        clk;
    logic        reset;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wdata;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic        ertn_flush;
    logic [31:0] coreid_in;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic        has_int;

    // reference copy of the architectural state
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ecfg;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_tcfg;
    logic [31:0] m_tval;
    logic [31:0] m_tid;
    logic [31:0] m_save [SAVE_COUNT];
    logic [12:0] m_is;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] exp_rvalue;
    logic [31:0] exp_entry;
    logic        exp_has_int;
    logic [31:0] wr_value;                      // merged value of the CSR being written
    logic        reads_armed = 1'b0;            // set once every register holds a value
    logic        has_int_seen = 1'b0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    csr_top #(.SAVE_COUNT(SAVE_COUNT)) UUT (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    always_comb begin
        exp_rvalue = '0;
        case (csr_num)
            csr_addr_pkg::CSR_CRMD:   exp_rvalue = m_crmd;
            csr_addr_pkg::CSR_PRMD:   exp_rvalue = m_prmd;
            csr_addr_pkg::CSR_ECFG:   exp_rvalue = m_ecfg;
            csr_addr_pkg::CSR_ESTAT:  exp_rvalue = {1'b0, m_esub, m_ecode, 3'b0, m_is};
            csr_addr_pkg::CSR_ERA:    exp_rvalue = m_era;
            csr_addr_pkg::CSR_BADV:   exp_rvalue = m_badv;
            csr_addr_pkg::CSR_EENTRY: exp_rvalue = m_eentry;
            csr_addr_pkg::CSR_TID:    exp_rvalue = m_tid;
            csr_addr_pkg::CSR_TCFG:   exp_rvalue = m_tcfg;
            csr_addr_pkg::CSR_TVAL:   exp_rvalue = m_tval;
            default: ;
        endcase
        if (csr_num >= csr_addr_pkg::CSR_SAVE0
            && csr_num < csr_addr_pkg::CSR_SAVE0 + SAVE_COUNT) begin
            exp_rvalue = m_save[csr_num - csr_addr_pkg::CSR_SAVE0];
        end
        wr_value    = (csr_wdata & csr_wmask) | (exp_rvalue & ~csr_wmask);
        exp_entry   = wb_ex ? m_eentry : (ertn_flush ? m_era : 32'h0);
        exp_has_int = (|(m_is & m_ecfg[12:0])) && m_crmd[2];
    end

    always @(posedge clk) begin
        if (reset) begin
            m_crmd <= 32'h8;                    // DA set
            m_prmd <= '0;
            m_ecfg <= '0;
            m_is   <= '0;
            m_tcfg <= '0;
            m_tval <= '1;
            m_tid  <= coreid_in;
        end else begin
            m_is[9:2] <= hw_int_in;
            m_is[12]  <= ipi_int_in;
            if (m_tval == '0) begin
                m_is[11] <= 1'b1;
            end else if (csr_we && csr_num == csr_addr_pkg::CSR_TICLR && wr_value[0]) begin
                m_is[11] <= 1'b0;
            end
            if (csr_we && csr_num == csr_addr_pkg::CSR_TCFG && wr_value[0]) begin
                m_tval <= (wr_value >> 2) * 4;  // InitVal times four
            end else if (m_tcfg[0] && m_tval != '1) begin
                m_tval <= (m_tval == '0 && m_tcfg[1]) ? (m_tcfg >> 2) * 4 : m_tval - 1;
            end
            if (wb_ex) begin
                m_prmd[2:0] <= m_crmd[2:0];
                m_crmd[2:0] <= 3'b000;
                m_era       <= wb_pc;
                m_ecode     <= wb_ecode;
                m_esub      <= wb_esubcode;
                if (wb_ecode == csr_addr_pkg::ECODE_ADE && wb_esubcode == 9'd0) begin
                    m_badv <= wb_pc;
                end else if (wb_ecode == csr_addr_pkg::ECODE_ADE
                             || wb_ecode == csr_addr_pkg::ECODE_ALE) begin
                    m_badv <= wb_vaddr;
                end
            end else if (ertn_flush) begin
                m_crmd[2:0] <= m_prmd[2:0];
            end else if (csr_we) begin
                case (csr_num)
                    csr_addr_pkg::CSR_CRMD:   m_crmd <= wr_value & 32'h1ff;
                    csr_addr_pkg::CSR_PRMD:   m_prmd <= wr_value & 32'h7;
                    csr_addr_pkg::CSR_ECFG:   m_ecfg <= wr_value & 32'h1bff;  // no bit 10
                    csr_addr_pkg::CSR_ESTAT:  m_is[1:0] <= wr_value[1:0];
                    csr_addr_pkg::CSR_ERA:    m_era <= wr_value;
                    csr_addr_pkg::CSR_BADV:   m_badv <= wr_value;
                    csr_addr_pkg::CSR_EENTRY: m_eentry <= wr_value & 32'hffff_f000;
                    csr_addr_pkg::CSR_TID:    m_tid <= wr_value;
                    csr_addr_pkg::CSR_TCFG:   m_tcfg <= wr_value;
                    default: begin
                        if (csr_num >= csr_addr_pkg::CSR_SAVE0
                            && csr_num < csr_addr_pkg::CSR_SAVE0 + SAVE_COUNT) begin
                            m_save[csr_num - csr_addr_pkg::CSR_SAVE0] <= wr_value;
                        end
                    end
                endcase
            end
        end
    end

    always @(posedge clk) begin
        if (has_int) has_int_seen <= 1'b1;
    end

    a_read_value: assert property (@(posedge clk) disable iff (reset)
        !reads_armed || csr_rvalue == exp_rvalue)
        else abort_run($sformatf("Error: %0t csr_rvalue %h for CSR %h, expected %h",
                                 $time, csr_rvalue, csr_num, exp_rvalue));

    a_entry: assert property (@(posedge clk) disable iff (reset) ex_entry == exp_entry)
        else abort_run($sformatf("Error: %0t ex_entry %h, expected %h",
                                 $time, ex_entry, exp_entry));

    a_has_int: assert property (@(posedge clk) disable iff (reset) has_int == exp_has_int)
        else abort_run($sformatf("Error: %0t has_int %b, expected %b",
                                 $time, has_int, exp_has_int));

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] data);
        @(posedge clk);
        csr_num   <= num;
        csr_we    <= 1'b1;
        csr_wmask <= mask;
        csr_wdata <= data;
        @(posedge clk);
        csr_we    <= 1'b0;                      // num kept, so the new value is read back
    endtask

    task automatic read_csr(input logic [13:0] num);
        @(posedge clk);
        csr_num <= num;
    endtask

    task automatic raise_exception(input logic [5:0] code, input logic [8:0] sub,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= code;
        wb_esubcode <= sub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex       <= 1'b0;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    // polls a CSR at the falling edge until it shows the value
    task automatic wait_read_value(input logic [13:0] num, input logic [31:0] value,
                                   input int limit, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        while (csr_rvalue != value && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (csr_rvalue != value) abort_run({"Timed out waiting for ", what});
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        int          pick;
        logic [13:0] num;
        logic [5:0]  code;
        logic [8:0]  sub;
        void'($urandom(RANDOM_SEED));
        reset       <= 1'b1;
        csr_num     <= csr_addr_pkg::CSR_TID;
        csr_we      <= 1'b0;
        csr_wmask   <= '0;
        csr_wdata   <= '0;
        hw_int_in   <= '0;
        ipi_int_in  <= 1'b0;
        wb_ex       <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        wb_vaddr    <= '0;
        ertn_flush  <= 1'b0;
        coreid_in   <= 32'h0000_0005;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // registers without reset get a full value first
        for (int i = 0; i < SAVE_COUNT; i++) begin
            write_csr(14'(csr_addr_pkg::CSR_SAVE0 + i), '1, $urandom());
        end
        write_csr(csr_addr_pkg::CSR_ERA, '1, 32'h1c00_0100);
        write_csr(csr_addr_pkg::CSR_BADV, '1, 32'h0);
        write_csr(csr_addr_pkg::CSR_EENTRY, '1, 32'h1c00_8000);
        raise_exception(6'h0b, 9'd0, 32'h1c00_0040, 32'h0);   // syscall
        return_from_exception();
        @(posedge clk);
        reads_armed <= 1'b1;

        read_csr(csr_addr_pkg::CSR_TID);
        read_csr(14'h3ff);                      // unknown number
        read_csr(csr_addr_pkg::CSR_TICLR);

        for (int n = 0; n < RANDOM_WRITES; n++) begin
            pick = $urandom_range(6);
            case (pick)
                4:       num = csr_addr_pkg::CSR_ERA;
                5:       num = csr_addr_pkg::CSR_EENTRY;
                6:       num = csr_addr_pkg::CSR_ECFG;
                default: num = 14'(csr_addr_pkg::CSR_SAVE0 + pick);
            endcase
            write_csr(num, $urandom(), $urandom());
        end

        // ADEF, ADEM, ALE, then a code that keeps BADV
        for (int k = 0; k < 4; k++) begin
            write_csr(csr_addr_pkg::CSR_CRMD, 32'h7, $urandom());
            code = (k < 2) ? csr_addr_pkg::ECODE_ADE : (k == 2 ? csr_addr_pkg::ECODE_ALE : 6'h0b);
            sub  = (k == 1) ? 9'd1 : 9'd0;
            raise_exception(code, sub, $urandom() & 32'hffff_fffc, $urandom());
            read_csr(csr_addr_pkg::CSR_PRMD);
            read_csr(csr_addr_pkg::CSR_ERA);
            read_csr(csr_addr_pkg::CSR_ESTAT);
            read_csr(csr_addr_pkg::CSR_BADV);
            read_csr(csr_addr_pkg::CSR_CRMD);
            return_from_exception();
            read_csr(csr_addr_pkg::CSR_CRMD);
        end

        write_csr(csr_addr_pkg::CSR_CRMD, 32'h4, 32'h4);    // IE on so has_int follows IS[11]
        write_csr(csr_addr_pkg::CSR_ECFG, '1, '1);
        write_csr(csr_addr_pkg::CSR_TCFG, '1, (TIMER_INIT << 2) | 32'h1);    // one-shot
        wait_read_value(csr_addr_pkg::CSR_TVAL, '1, TIMER_INIT * 4 + 8, "one-shot expiry");
        repeat (4) @(posedge clk);              // idle counter must hold
        read_csr(csr_addr_pkg::CSR_ESTAT);
        write_csr(csr_addr_pkg::CSR_TICLR, 32'h1, 32'h1);
        write_csr(csr_addr_pkg::CSR_TCFG, '1, (TIMER_INIT << 2) | 32'h3);    // periodic
        wait_read_value(csr_addr_pkg::CSR_TVAL, 32'h0, TIMER_INIT * 4 + 8, "periodic zero");
        wait_read_value(csr_addr_pkg::CSR_TVAL, TIMER_INIT * 4, 4, "periodic reload");
        write_csr(csr_addr_pkg::CSR_TCFG, 32'h1, 32'h0);
        write_csr(csr_addr_pkg::CSR_TICLR, 32'h1, 32'h1);
        read_csr(csr_addr_pkg::CSR_ESTAT);

        write_csr(csr_addr_pkg::CSR_ESTAT, 32'h3, 32'h2);
        for (int n = 0; n < 40; n++) begin
            @(posedge clk);
            hw_int_in  <= 8'($urandom());
            ipi_int_in <= 1'($urandom_range(1));
        end
        @(posedge clk);
        hw_int_in  <= '0;
        ipi_int_in <= 1'b0;
        write_csr(csr_addr_pkg::CSR_ESTAT, 32'h3, 32'h0);
        write_csr(csr_addr_pkg::CSR_ECFG, '1, 32'h0);
        repeat (4) @(posedge clk);

        if (!has_int_seen) begin
            abort_run("The interrupt request was never raised during the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/csr_types_pkg.sv
design/csr_addr_pkg.sv
design/csr_trap_regs.sv
design/csr_timer_int.sv
design/csr_scratch_regs.sv
design/csr_read_mux.sv
design/csr_top.sv
dv/tb_clock_gen.sv
dv/csr_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= csr_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall -Wno-fatal
PASS_TEXT  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the simulation printed the pass line
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
